// File: design/pi_bus_pkg.sv
`default_nettype none

package pi_bus_pkg;

   localparam int data_w     = 32;
   localparam int tout_limit = 63;   // cycles in cs_data before abandoning
   localparam int tout_cnt_w = 6;

   typedef enum logic [3:0] {
      opc_nop  = 4'd0,               // no transfer on the bus
      opc_word = 4'd1                // single word transfer
   } opc_t;

   typedef enum logic [2:0] {
      ack_none = 3'd0,
      ack_rdy  = 3'd1,
      ack_wat  = 3'd2,               // slave inserts a wait state
      ack_err  = 3'd3
   } ack_t;

   typedef enum logic [1:0] {
      st_ok   = 2'd0,
      st_err  = 2'd1,
      st_tout = 2'd2                 // nobody answered
   } status_t;

   typedef enum logic [2:0] {
      cs_idle = 3'd0,
      cs_req  = 3'd1,
      cs_addr = 3'd2,
      cs_data = 3'd3
   } cont_state_t;

endpackage

`default_nettype wire

// File: design/pi_map_pkg.sv
`default_nettype none

package pi_map_pkg;

   localparam int sel_w     = 2;
   localparam int off_w     = 28;
   localparam int addr_w    = sel_w + off_w;   // 30 bit word address
   localparam int mem_depth = 16;
   localparam int mem_idx_w = 4;

   localparam logic [sel_w-1:0] mem_sel_pattern = 2'b11;

   typedef struct packed {
      logic [sel_w-1:0] sel_field;   // slave select, top bits
      logic [off_w-1:0] offset;      // word offset inside the slave
   } pi_addr_fld_t;

   // same address word, seen as select plus offset or as one raw index
   typedef union packed {
      pi_addr_fld_t      fld;
      logic [addr_w-1:0] raw;
   } pi_addr_u;

endpackage

`default_nettype wire

// File: design/pi_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module pi_host_port
(
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               cmd_req,
   input  wire                               cmd_read,
   input  wire                               cmd_lock,
   input  wire pi_map_pkg::pi_addr_u         cmd_addr,
   input  wire [pi_bus_pkg::data_w-1:0]      cmd_wdata,
   input  wire                               bus_gnt,
   input  wire pi_bus_pkg::ack_t             bus_ack,
   input  wire [pi_bus_pkg::data_w-1:0]      bus_rdata,
   input  wire                               bus_tout,
   output logic                              cmd_ack,
   output logic [pi_bus_pkg::data_w-1:0]     rsp_rdata,
   output pi_bus_pkg::status_t               rsp_status,
   output logic                              bus_req,
   output pi_bus_pkg::opc_t                  bus_opc,
   output pi_map_pkg::pi_addr_u              bus_a,
   output logic                              bus_read,
   output logic                              bus_lock,
   output logic [pi_bus_pkg::data_w-1:0]     bus_wdata
);
   import pi_bus_pkg::*;

   typedef enum logic [2:0] {
      ps_idle,
      ps_wait_gnt,
      ps_xfer,
      ps_resp,
      ps_release
   } port_state_t;

   port_state_t state;
   logic        owned;                // bus kept under lock from last transfer
   logic        xfer_end;

   assign bus_opc  = (state == ps_xfer) ? opc_word : opc_nop;
   assign xfer_end = (state == ps_xfer) &&
                     (bus_tout || (bus_ack == ack_rdy) || (bus_ack == ack_err));

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= ps_idle;
         bus_req  <= 1'b0;
         cmd_ack  <= 1'b0;
         owned    <= 1'b0;
         bus_lock <= 1'b0;
      end
      else
      begin
         case (state)
            ps_idle:
               if (cmd_req)
               begin
                  bus_lock <= cmd_lock;
                  if (owned)
                     state <= ps_xfer;       // controller still waits in cs_addr
                  else
                  begin
                     bus_req <= 1'b1;
                     state   <= ps_wait_gnt;
                  end
               end
            ps_wait_gnt:
               if (bus_gnt)
               begin
                  bus_req <= 1'b0;
                  state   <= ps_xfer;
               end
            ps_xfer:
               if (xfer_end)
               begin
                  cmd_ack <= 1'b1;
                  owned   <= bus_lock && !bus_tout;   // timeout drops ownership
                  state   <= ps_resp;
               end
            ps_resp:
               if (!cmd_req)
               begin
                  cmd_ack <= 1'b0;
                  state   <= ps_release;
               end
            ps_release:
               state <= ps_idle;             // guard cycle before next command
            default:
               state <= ps_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == ps_idle) && cmd_req)
      begin
         bus_read  <= cmd_read;
         bus_a     <= cmd_addr;
         bus_wdata <= cmd_wdata;
      end
      if (xfer_end)
      begin
         if (bus_tout)
            rsp_status <= st_tout;
         else if (bus_ack == ack_err)
            rsp_status <= st_err;
         else
            rsp_status <= st_ok;
         rsp_rdata <= (bus_read && !bus_tout && (bus_ack == ack_rdy)) ? bus_rdata : '0;
      end
   end

endmodule

`default_nettype wire

// File: design/pi_bus_cont.sv
`timescale 1ns/1ps
`default_nettype none

module pi_bus_cont
(
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        bus_req,
   input  wire pi_bus_pkg::opc_t      bus_opc,
   input  wire pi_map_pkg::pi_addr_u  bus_a,
   input  wire                        bus_lock,
   input  wire pi_bus_pkg::ack_t      bus_ack,
   output logic                       bus_gnt,
   output logic                       bus_sel,
   output logic                       bus_tout
);
   import pi_bus_pkg::*;
   import pi_map_pkg::*;

   cont_state_t           state;
   cont_state_t           end_state;   // where a finished transfer goes
   logic [tout_cnt_w-1:0] tout_cnt;
   logic                  sel_hit;
   logic                  slave_done;

   assign sel_hit    = (bus_opc != opc_nop) && (bus_a.fld.sel_field == mem_sel_pattern);
   assign bus_sel    = ((state == cs_addr) || (state == cs_data)) && sel_hit;
   assign slave_done = (bus_ack == ack_rdy) || (bus_ack == ack_err);

   // lock keeps the bus, otherwise a pending request is granted at once
   always_comb
   begin
      if (bus_lock)
         end_state = cs_addr;
      else if (bus_req)
         end_state = cs_req;
      else
         end_state = cs_idle;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= cs_idle;
         bus_gnt  <= 1'b0;
         bus_tout <= 1'b0;
         tout_cnt <= '0;
      end
      else
      begin
         bus_gnt  <= 1'b0;                   // both are single cycle pulses
         bus_tout <= 1'b0;
         case (state)
            cs_idle:
            begin
               tout_cnt <= '0;
               if (bus_req)
               begin
                  bus_gnt <= 1'b1;
                  state   <= cs_req;
               end
            end
            cs_req:
               state <= cs_addr;             // master drives the address next
            cs_addr:
            begin
               tout_cnt <= '0;
               if ((bus_opc == opc_nop) || slave_done)
               begin
                  bus_gnt <= (end_state == cs_req);
                  state   <= end_state;
               end
               else
                  state <= cs_data;
            end
            cs_data:
            begin
               if (slave_done)
               begin
                  tout_cnt <= '0;
                  bus_gnt  <= (end_state == cs_req);
                  state    <= end_state;
               end
               else if (tout_cnt == tout_cnt_w'(tout_limit - 1))
               begin
                  // no slave answer, give the bus up
                  tout_cnt <= '0;
                  bus_tout <= 1'b1;
                  state    <= cs_idle;
               end
               else
                  tout_cnt <= tout_cnt + 1'b1;
            end
            default:
               state <= cs_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/pi_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module pi_mem_slave
(
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            bus_sel,
   input  wire                            bus_read,
   input  wire pi_map_pkg::pi_addr_u      bus_a,
   input  wire [pi_bus_pkg::data_w-1:0]   bus_wdata,
   output pi_bus_pkg::ack_t               bus_ack,
   output logic [pi_bus_pkg::data_w-1:0]  bus_rdata
);
   import pi_bus_pkg::*;
   import pi_map_pkg::*;

   logic [data_w-1:0]    mem [mem_depth];
   logic [mem_idx_w-1:0] mem_idx;
   logic                 range_err;
   logic                 wat_cnt;            // second wait state pending

   assign mem_idx   = bus_a.raw[mem_idx_w-1:0];
   assign range_err = |bus_a.raw[off_w-1:mem_idx_w];   // offset past mem_depth

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         bus_ack <= ack_none;
         wat_cnt <= 1'b0;
         for (int i = 0; i < mem_depth; i++)
            mem[i] <= '0;
      end
      else if (!bus_sel)
      begin
         bus_ack <= ack_none;
         wat_cnt <= 1'b0;
      end
      else
      begin
         case (bus_ack)
            ack_none:
               if (range_err)
                  bus_ack <= ack_err;
               else if (bus_read)
               begin
                  bus_ack <= ack_wat;
                  wat_cnt <= 1'b0;
               end
               else
               begin
                  mem[mem_idx] <= bus_wdata;   // write completes at once
                  bus_ack      <= ack_rdy;
               end
            ack_wat:
               if (wat_cnt)
                  bus_ack <= ack_rdy;
               else
                  wat_cnt <= 1'b1;
            default:
               bus_ack <= ack_none;          // transfer ended, stay quiet
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (bus_sel && (bus_ack == ack_wat) && wat_cnt)
         bus_rdata <= mem[mem_idx];        // valid with ack_rdy
   end

endmodule

`default_nettype wire

// File: design/pi_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module pi_bus_top
(
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire                              cmd_req,
   input  wire                              cmd_read,
   input  wire                              cmd_lock,
   input  wire pi_map_pkg::pi_addr_u        cmd_addr,
   input  wire [pi_bus_pkg::data_w-1:0]     cmd_wdata,
   output logic                             cmd_ack,
   output logic [pi_bus_pkg::data_w-1:0]    rsp_rdata,
   output pi_bus_pkg::status_t              rsp_status
);
   import pi_bus_pkg::*;
   import pi_map_pkg::*;

   logic              bus_req;
   logic              bus_gnt;
   opc_t              bus_opc;
   pi_addr_u          bus_a;
   logic              bus_read;
   logic              bus_lock;
   logic [data_w-1:0] bus_wdata;
   logic              bus_sel;
   logic              bus_tout;
   ack_t              bus_ack;
   logic [data_w-1:0] bus_rdata;

   pi_host_port u_port
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_req    (cmd_req),
      .cmd_read   (cmd_read),
      .cmd_lock   (cmd_lock),
      .cmd_addr   (cmd_addr),
      .cmd_wdata  (cmd_wdata),
      .bus_gnt    (bus_gnt),
      .bus_ack    (bus_ack),
      .bus_rdata  (bus_rdata),
      .bus_tout   (bus_tout),
      .cmd_ack    (cmd_ack),
      .rsp_rdata  (rsp_rdata),
      .rsp_status (rsp_status),
      .bus_req    (bus_req),
      .bus_opc    (bus_opc),
      .bus_a      (bus_a),
      .bus_read   (bus_read),
      .bus_lock   (bus_lock),
      .bus_wdata  (bus_wdata)
   );

   pi_bus_cont u_cont
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus_req  (bus_req),
      .bus_opc  (bus_opc),
      .bus_a    (bus_a),
      .bus_lock (bus_lock),
      .bus_ack  (bus_ack),
      .bus_gnt  (bus_gnt),
      .bus_sel  (bus_sel),
      .bus_tout (bus_tout)
   );

   pi_mem_slave u_slave
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus_sel   (bus_sel),
      .bus_read  (bus_read),
      .bus_a     (bus_a),
      .bus_wdata (bus_wdata),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata)
   );

endmodule

`default_nettype wire

// File: tb/pi_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pi_clk_gen
(
   output logic clk,
   output logic rst_n
);

   initial clk = 1'b0;
   always #10 clk = ~clk;             // 20 ns period

   initial
   begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;                   // released just after the 4th edge
   end

endmodule

`default_nettype wire

// File: tb/pi_bus_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pi_bus_chk
(
   input wire                    clk,
   input wire                    rst_n,
   input wire                    bus_gnt,
   input wire                    bus_sel,
   input wire                    bus_tout,
   input wire pi_bus_pkg::ack_t  bus_ack
);
   import pi_bus_pkg::*;

   int fail_cnt;                      // read by the testbench at the end

   initial fail_cnt = 0;

   gnt_pulse: assert property (@(posedge clk) disable iff (!rst_n) bus_gnt |=> !bus_gnt)
   else
   begin
      fail_cnt++;
      $error("bus_gnt stayed high for two cycles");
   end

   ack_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                               !bus_sel |=> (bus_ack == ack_none))
   else
   begin
      fail_cnt++;
      $error("bus_ack active although bus_sel was low");
   end

   tout_vs_sel: assert property (@(posedge clk) disable iff (!rst_n) !(bus_tout && bus_sel))
   else
   begin
      fail_cnt++;
      $error("bus_tout and bus_sel high together");
   end

endmodule

bind pi_bus_cont pi_bus_chk u_chk
(
   .clk      (clk),
   .rst_n    (rst_n),
   .bus_gnt  (bus_gnt),
   .bus_sel  (bus_sel),
   .bus_tout (bus_tout),
   .bus_ack  (bus_ack)
);

`default_nettype wire

// File: tb/pi_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pi_bus_tb;
   import pi_bus_pkg::*;
   import pi_map_pkg::*;

   localparam int n_entries = 23;
   localparam int cycle_limit = n_entries * (tout_limit + 20);

   logic              clk;
   logic              rst_n;
   logic              cmd_req;
   logic              cmd_read;
   logic              cmd_lock;
   pi_addr_u          cmd_addr;
   logic [data_w-1:0] cmd_wdata;
   logic              cmd_ack;
   logic [data_w-1:0] rsp_rdata;
   status_t           rsp_status;

   // stimulus and expected results, one entry per host command
   logic              tbl_read   [n_entries];
   logic              tbl_lock   [n_entries];
   logic [addr_w-1:0] tbl_addr   [n_entries];
   logic [data_w-1:0] tbl_wdata  [n_entries];
   int                tbl_hold   [n_entries];   // extra cycles cmd_req stays high
   logic [1:0]        tbl_status [n_entries];
   logic [data_w-1:0] tbl_rdata  [n_entries];

   logic [data_w-1:0] model [mem_depth];          // expected memory contents
   int                n_built;
   int                err_cnt;
   int                check_cnt;
   int                total;
   int                cycle_cnt;

   pi_clk_gen u_clk_gen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   pi_bus_top UUT
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_req    (cmd_req),
      .cmd_read   (cmd_read),
      .cmd_lock   (cmd_lock),
      .cmd_addr   (cmd_addr),
      .cmd_wdata  (cmd_wdata),
      .cmd_ack    (cmd_ack),
      .rsp_rdata  (rsp_rdata),
      .rsp_status (rsp_status)
   );

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      check_cnt++;
      if (got !== expected)
      begin
         err_cnt++;
         $display("ERR %0d ns: %s, got %h, expected %h", $time, what, got, expected);
      end
   endtask

   // predicts the result from the address map rules
   task automatic add_entry(input logic rd, input logic lk, input logic [sel_w-1:0] sel,
                            input logic [off_w-1:0] off, input int hold);
      logic [data_w-1:0] wd;
      wd                  = $urandom();
      tbl_read[n_built]   = rd;
      tbl_lock[n_built]   = lk;
      tbl_addr[n_built]   = {sel, off};
      tbl_wdata[n_built]  = wd;
      tbl_hold[n_built]   = hold;
      tbl_rdata[n_built]  = '0;
      if (sel != mem_sel_pattern)
         tbl_status[n_built] = st_tout;    // nobody decodes this select
      else if (32'(off) >= mem_depth)
         tbl_status[n_built] = st_err;
      else
      begin
         tbl_status[n_built] = st_ok;
         if (rd)
            tbl_rdata[n_built] = model[off[mem_idx_w-1:0]];
         else
            model[off[mem_idx_w-1:0]] = wd;
      end
      n_built++;
   endtask

   task automatic build_table();
      for (int w = 0; w < mem_depth; w++)
         model[w] = '0;                    // memory is cleared by reset
      n_built = 0;
      add_entry(1'b1, 1'b0, 2'b11, 28'd2, 0);      // unwritten words
      add_entry(1'b1, 1'b0, 2'b11, 28'd5, 0);
      add_entry(1'b0, 1'b0, 2'b11, 28'd0, 0);
      add_entry(1'b0, 1'b0, 2'b11, 28'd1, 0);
      add_entry(1'b0, 1'b0, 2'b11, 28'd7, 0);
      add_entry(1'b0, 1'b0, 2'b11, 28'd15, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd7, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd0, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd15, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd1, 0);
      add_entry(1'b0, 1'b0, 2'b11, 28'd16, 0);     // aliases word 0 if decoded wrong
      add_entry(1'b1, 1'b0, 2'b11, 28'h100, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd0, 0);
      add_entry(1'b1, 1'b0, 2'b01, 28'd3, 0);      // unmapped select
      add_entry(1'b0, 1'b0, 2'b00, 28'd3, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd7, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd3, 0);
      add_entry(1'b0, 1'b1, 2'b11, 28'd9, 0);      // locked sequence
      add_entry(1'b1, 1'b1, 2'b11, 28'd9, 0);
      add_entry(1'b1, 1'b0, 2'b11, 28'd9, 0);
      add_entry(1'b0, 1'b0, 2'b11, 28'd4, 5);      // host holds cmd_req
      add_entry(1'b1, 1'b0, 2'b11, 28'd4, 6);
      add_entry(1'b1, 1'b0, 2'b11, 28'd15, 0);
   endtask

   task automatic wait_ack(input logic level);
      while (cmd_ack !== level)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic run_entry(input int i);
      logic [data_w-1:0] held_rdata;
      cmd_read  = tbl_read[i];
      cmd_lock  = tbl_lock[i];
      cmd_addr  = tbl_addr[i];
      cmd_wdata = tbl_wdata[i];
      cmd_req   = 1'b1;
      wait_ack(1'b1);
      held_rdata = rsp_rdata;
      check_value($sformatf("entry %0d status", i), 32'(rsp_status), 32'(tbl_status[i]));
      if (tbl_read[i] && (tbl_status[i] == st_ok))
         check_value($sformatf("entry %0d read data", i), rsp_rdata, tbl_rdata[i]);
      for (int k = 0; k < tbl_hold[i]; k++)
      begin
         @(posedge clk);
         #1;
         check_value($sformatf("entry %0d held status", i), 32'(rsp_status),
                     32'(tbl_status[i]));
         check_value($sformatf("entry %0d held data", i), rsp_rdata, held_rdata);
         check_value($sformatf("entry %0d held ack", i), 32'(cmd_ack), 32'd1);
      end
      cmd_req = 1'b0;
      wait_ack(1'b0);
   endtask

   initial
   begin
      cmd_req   = 1'b0;
      cmd_read  = 1'b0;
      cmd_lock  = 1'b0;
      cmd_addr  = '0;
      cmd_wdata = '0;
      err_cnt   = 0;
      check_cnt = 0;
      void'($urandom(61304));
      build_table();
      @(posedge rst_n);
      @(posedge clk);
      #1;
      check_value("cmd_ack after reset", 32'(cmd_ack), 32'd0);
      for (int i = 0; i < n_entries; i++)
         run_entry(i);
      total = err_cnt + UUT.u_cont.u_chk.fail_cnt;
      $display("errors: %0d, checks: %0d, assertion failures: %0d",
               err_cnt, check_cnt, UUT.u_cont.u_chk.fail_cnt);
      if (total == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   // watchdog against a DUT that never answers
   initial cycle_cnt = 0;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("the run hung: no end after %0d clock cycles, errors so far: %0d",
                  cycle_limit, err_cnt);
         $display("Finished with errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: files.f
design/pi_bus_pkg.sv
design/pi_map_pkg.sv
design/pi_host_port.sv
design/pi_bus_cont.sv
design/pi_mem_slave.sv
design/pi_bus_top.sv
tb/pi_clk_gen.sv
tb/pi_bus_chk.sv
tb/pi_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the PI bus testbench with Verilator and runs it
# the run passes only if the simulation prints its pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module pi_bus_tb -o pi_bus_sim \
   && ./obj_dir/pi_bus_sim | tee /dev/stderr | grep -q "Finished with no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
